// File: source/ps2_pkg.sv
`default_nettype none

package ps2_pkg;

	////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////

	// one payload byte on the wire
	typedef logic [7:0] ps2_byte_t;
	// start, d0..d7, odd parity, stop (bit 0 is start)
	typedef logic [10:0] ps2_frame_t;
	// counts falling edges inside one frame
	typedef logic [3:0] ps2_bitcnt_t;
	// counts 100 us ticks
	typedef logic [7:0] ps2_ticks_t;
	// index into the command table
	typedef logic [1:0] ps2_cmd_idx_t;

	////////////////////////////////////////////////////////////
	// timing, all relative to a 10 MHz qzt_clk
	////////////////////////////////////////////////////////////

	// 2 MHz line sampling
	localparam int SAMPLE_DIV = 5;
	// 100 us tick
	localparam int TICK_DIV = 1000;
	typedef logic [$clog2(SAMPLE_DIV)-1:0] ps2_sdiv_t;
	typedef logic [$clog2(TICK_DIV)-1:0] ps2_tdiv_t;

	// clock held low before request-to-send
	localparam ps2_ticks_t INHIBIT_TICKS = 8'd2;
	// wait for a start bit after an acked command
	localparam ps2_ticks_t RESP_WAIT_TICKS = 8'd70;
	// pause before the next command
	localparam ps2_ticks_t GAP_TICKS = 8'd20;
	// give up on a silent device while sending
	localparam ps2_ticks_t TX_TIMEOUT_TICKS = 8'd150;

	////////////////////////////////////////////////////////////
	// startup commands: get id, stream mode, enable reporting
	////////////////////////////////////////////////////////////
	localparam int N_CMDS = 3;
	localparam ps2_byte_t cmd_table [N_CMDS] = '{8'hF2, 8'hEA, 8'hF4};

	typedef enum logic [2:0] {IDLE, SEND, SEND_WAIT, LISTEN, RECEIVE, GAP} seq_state_t;

endpackage

`default_nettype wire

// File: source/ps2_link_if.sv
`default_nettype none

interface ps2_link_if;
	// sequencer to tx engine
	logic                tx_start;
	ps2_pkg::ps2_byte_t  tx_byte;
	// tx engine back to sequencer
	logic                tx_done;
	logic                tx_nack;
	// sequencer to rx engine
	logic                rx_enable;
	// rx engine back to sequencer
	logic                rx_busy;
	logic                rx_valid;
	ps2_pkg::ps2_byte_t  rx_byte;
	logic                rx_err;

	modport seq (
		output tx_start, tx_byte, rx_enable,
		input  tx_done, tx_nack, rx_busy, rx_valid, rx_byte, rx_err
	);
	modport tx (input tx_start, tx_byte, output tx_done, tx_nack);
	modport rx (input rx_enable, output rx_busy, rx_valid, rx_byte, rx_err);
endinterface

`default_nettype wire

// File: source/ps2_timebase.sv
`default_nettype none

module ps2_timebase (
	input  logic qzt_clk,
	input  logic rst,
	output logic sample_stb,
	output logic tick_100us
);
	ps2_pkg::ps2_sdiv_t sample_cnt;
	ps2_pkg::ps2_tdiv_t tick_cnt;

	////////////////////////////////////////////////////////////
	// line sampling strobe
	////////////////////////////////////////////////////////////
	always_ff @(posedge qzt_clk) begin
		if (rst) begin
			sample_cnt <= '0;
			sample_stb <= 1'b0;
		end else begin
			// strobe on the last count, then wrap
			sample_stb <= (sample_cnt == ps2_pkg::ps2_sdiv_t'(ps2_pkg::SAMPLE_DIV - 1));
			if (sample_cnt == ps2_pkg::ps2_sdiv_t'(ps2_pkg::SAMPLE_DIV - 1))
				sample_cnt <= '0;
			else
				sample_cnt <= sample_cnt + ps2_pkg::ps2_sdiv_t'(1);
		end
	end

	////////////////////////////////////////////////////////////
	// 100 us timer tick
	////////////////////////////////////////////////////////////
	always_ff @(posedge qzt_clk) begin
		if (rst) begin
			tick_cnt <= '0;
			tick_100us <= 1'b0;
		end else begin
			tick_100us <= (tick_cnt == ps2_pkg::ps2_tdiv_t'(ps2_pkg::TICK_DIV - 1));
			if (tick_cnt == ps2_pkg::ps2_tdiv_t'(ps2_pkg::TICK_DIV - 1))
				tick_cnt <= '0;
			else
				tick_cnt <= tick_cnt + ps2_pkg::ps2_tdiv_t'(1);
		end
	end
endmodule

`default_nettype wire

// File: source/ps2_host_tx.sv
`default_nettype none

module ps2_host_tx (
	input  logic   qzt_clk,
	input  logic   rst,
	input  logic   sample_stb,
	input  logic   tick_100us,
	ps2_link_if.tx link,
	input  logic   ps2_clk_in,
	input  logic   ps2_data_in,
	output logic   clk_drive_low,
	output logic   data_drive_low
);
	typedef enum logic [1:0] {TX_IDLE, TX_INHIBIT, TX_BITS, TX_ACK} tx_state_t;

	tx_state_t            state;
	logic [1:0]           clk_sync;
	logic [1:0]           data_sync;
	logic                 clk_prev;
	logic                 clk_fall;
	ps2_pkg::ps2_frame_t  frame;
	ps2_pkg::ps2_bitcnt_t bit_cnt;
	ps2_pkg::ps2_ticks_t  tick_cnt;

	////////////////////////////////////////////////////////////
	// line synchronizers and edge detect
	////////////////////////////////////////////////////////////
	always_ff @(posedge qzt_clk) begin
		if (rst) begin
			// idle lines are high
			clk_sync <= 2'b11;
			data_sync <= 2'b11;
			clk_prev <= 1'b1;
		end else begin
			clk_sync <= {clk_sync[0], ps2_clk_in};
			data_sync <= {data_sync[0], ps2_data_in};
			if (sample_stb)
				clk_prev <= clk_sync[1];
		end
	end

	// high then low across two strobes
	assign clk_fall = sample_stb & clk_prev & ~clk_sync[1];

	////////////////////////////////////////////////////////////
	// frame shift register
	////////////////////////////////////////////////////////////
	always_ff @(posedge qzt_clk) begin
		if (state == TX_IDLE && link.tx_start)
			// stop, odd parity, data, start
			frame <= {1'b1, ~^link.tx_byte, link.tx_byte, 1'b0};
		else if (state == TX_BITS && clk_fall)
			frame <= {1'b0, frame[10:1]};
	end

	////////////////////////////////////////////////////////////
	// frame FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge qzt_clk) begin
		if (rst) begin
			state <= TX_IDLE;
			clk_drive_low <= 1'b0;
			data_drive_low <= 1'b0;
			bit_cnt <= '0;
			tick_cnt <= '0;
			link.tx_done <= 1'b0;
			link.tx_nack <= 1'b0;
		end else begin
			link.tx_done <= 1'b0;
			if (tick_100us && state != TX_IDLE)
				tick_cnt <= tick_cnt + 8'd1;
			case (state)
				TX_IDLE: begin
					if (link.tx_start) begin
						// inhibit: hold clock low
						clk_drive_low <= 1'b1;
						data_drive_low <= 1'b0;
						tick_cnt <= '0;
						link.tx_nack <= 1'b0;
						state <= TX_INHIBIT;
					end
				end
				TX_INHIBIT: begin
					if (tick_cnt == ps2_pkg::INHIBIT_TICKS) begin
						// request-to-send, start bit on data, clock handed to device
						clk_drive_low <= 1'b0;
						data_drive_low <= ~frame[0];
						bit_cnt <= '0;
						tick_cnt <= '0;
						state <= TX_BITS;
					end
				end
				TX_BITS: begin
					// next bit goes out after each device falling edge
					if (clk_fall) begin
						data_drive_low <= ~frame[1];
						bit_cnt <= bit_cnt + 4'd1;
						// tenth edge puts out the stop bit, line released
						if (bit_cnt == 4'd9)
							state <= TX_ACK;
					end
				end
				TX_ACK: begin
					// device pulls data low for ack
					if (clk_fall) begin
						link.tx_done <= 1'b1;
						link.tx_nack <= data_sync[1];
						state <= TX_IDLE;
					end
				end
				default: state <= TX_IDLE;
			endcase
			// device stopped clocking, give up
			if ((state == TX_BITS || state == TX_ACK) && tick_cnt == ps2_pkg::TX_TIMEOUT_TICKS) begin
				clk_drive_low <= 1'b0;
				data_drive_low <= 1'b0;
				link.tx_done <= 1'b1;
				link.tx_nack <= 1'b1;
				state <= TX_IDLE;
			end
		end
	end
endmodule

`default_nettype wire

// File: source/ps2_host_rx.sv
`default_nettype none

module ps2_host_rx (
	input  logic   qzt_clk,
	input  logic   rst,
	input  logic   sample_stb,
	ps2_link_if.rx link,
	input  logic   ps2_clk_in,
	input  logic   ps2_data_in
);
	logic [1:0]           clk_sync;
	logic [1:0]           data_sync;
	logic                 clk_prev;
	logic                 clk_fall;
	ps2_pkg::ps2_frame_t  frame;
	ps2_pkg::ps2_frame_t  next_frame;
	ps2_pkg::ps2_bitcnt_t bit_cnt;
	logic                 frame_ok;

	////////////////////////////////////////////////////////////
	// line synchronizers and edge detect
	////////////////////////////////////////////////////////////
	always_ff @(posedge qzt_clk) begin
		if (rst) begin
			clk_sync <= 2'b11;
			data_sync <= 2'b11;
			clk_prev <= 1'b1;
		end else begin
			clk_sync <= {clk_sync[0], ps2_clk_in};
			data_sync <= {data_sync[0], ps2_data_in};
			if (sample_stb)
				clk_prev <= clk_sync[1];
		end
	end

	assign clk_fall = sample_stb & clk_prev & ~clk_sync[1];

	// LSB first, so new bits come in at the top
	assign next_frame = {data_sync[1], frame[10:1]};

	// start low, stop high, odd parity over data and parity bit
	assign frame_ok = ~next_frame[0] & next_frame[10] & (^next_frame[9:1]);

	////////////////////////////////////////////////////////////
	// payload
	////////////////////////////////////////////////////////////
	always_ff @(posedge qzt_clk) begin
		if (link.rx_enable && clk_fall) begin
			frame <= next_frame;
			if (bit_cnt == 4'd10)
				link.rx_byte <= next_frame[8:1];
		end
	end

	////////////////////////////////////////////////////////////
	// bit counting and result pulses
	////////////////////////////////////////////////////////////
	always_ff @(posedge qzt_clk) begin
		if (rst) begin
			bit_cnt <= '0;
			link.rx_busy <= 1'b0;
			link.rx_valid <= 1'b0;
			link.rx_err <= 1'b0;
		end else begin
			link.rx_valid <= 1'b0;
			link.rx_err <= 1'b0;
			if (!link.rx_enable) begin
				// abandon any partial frame quietly
				bit_cnt <= '0;
				link.rx_busy <= 1'b0;
			end else if (clk_fall) begin
				if (bit_cnt == 4'd10) begin
					// eleventh edge, frame complete
					bit_cnt <= '0;
					link.rx_busy <= 1'b0;
					link.rx_valid <= frame_ok;
					link.rx_err <= ~frame_ok;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
					link.rx_busy <= 1'b1;
				end
			end
		end
	end
endmodule

`default_nettype wire

// File: source/ps2_init_seq.sv
`default_nettype none

module ps2_init_seq (
	input  logic               qzt_clk,
	input  logic               rst,
	input  logic               tick_100us,
	input  logic               trigger,
	ps2_link_if.seq            link,
	output ps2_pkg::ps2_byte_t resp_byte,
	output logic               resp_valid,
	output logic               resp_err,
	output logic               cmd_nack,
	output logic               busy,
	output logic               seq_done
);
	ps2_pkg::seq_state_t   state;
	ps2_pkg::ps2_cmd_idx_t cmd_idx;
	ps2_pkg::ps2_ticks_t   tick_cnt;
	logic                  trig_q;
	logic                  trig_rise;

	assign trig_rise = trigger & ~trig_q;

	// one-cycle start while in SEND
	assign link.tx_start = (state == ps2_pkg::SEND);
	assign link.tx_byte = ps2_pkg::cmd_table[cmd_idx];
	// rx engine listens through the whole response window
	assign link.rx_enable = (state == ps2_pkg::LISTEN) || (state == ps2_pkg::RECEIVE);

	// captured response byte
	always_ff @(posedge qzt_clk) begin
		if (state == ps2_pkg::RECEIVE && link.rx_valid)
			resp_byte <= link.rx_byte;
	end

	////////////////////////////////////////////////////////////
	// sequencer FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge qzt_clk) begin
		if (rst) begin
			state <= ps2_pkg::IDLE;
			cmd_idx <= '0;
			tick_cnt <= '0;
			trig_q <= 1'b0;
			resp_valid <= 1'b0;
			resp_err <= 1'b0;
			cmd_nack <= 1'b0;
			busy <= 1'b0;
			seq_done <= 1'b0;
		end else begin
			trig_q <= trigger;
			resp_valid <= 1'b0;
			resp_err <= 1'b0;
			cmd_nack <= 1'b0;
			seq_done <= 1'b0;
			case (state)
				ps2_pkg::IDLE: begin
					// edges elsewhere are dropped
					if (trig_rise) begin
						cmd_idx <= '0;
						busy <= 1'b1;
						state <= ps2_pkg::SEND;
					end
				end
				ps2_pkg::SEND: state <= ps2_pkg::SEND_WAIT;
				ps2_pkg::SEND_WAIT: begin
					if (link.tx_done) begin
						tick_cnt <= '0;
						cmd_nack <= link.tx_nack;
						// no ack, no response to wait for
						state <= link.tx_nack ? ps2_pkg::GAP : ps2_pkg::LISTEN;
					end
				end
				ps2_pkg::LISTEN: begin
					// start bit seen, timer frozen
					if (link.rx_busy) begin
						state <= ps2_pkg::RECEIVE;
					end else if (tick_cnt == ps2_pkg::RESP_WAIT_TICKS) begin
						tick_cnt <= '0;
						state <= ps2_pkg::GAP;
					end else if (tick_100us) begin
						tick_cnt <= tick_cnt + 8'd1;
					end
				end
				ps2_pkg::RECEIVE: begin
					// rx pulses forwarded one register later
					if (link.rx_valid || link.rx_err || !link.rx_busy) begin
						resp_valid <= link.rx_valid;
						resp_err <= link.rx_err;
						tick_cnt <= '0;
						state <= ps2_pkg::GAP;
					end
				end
				ps2_pkg::GAP: begin
					if (tick_cnt == ps2_pkg::GAP_TICKS) begin
						tick_cnt <= '0;
						if (cmd_idx == ps2_pkg::ps2_cmd_idx_t'(ps2_pkg::N_CMDS - 1)) begin
							// last command finished
							seq_done <= 1'b1;
							busy <= 1'b0;
							state <= ps2_pkg::IDLE;
						end else begin
							cmd_idx <= cmd_idx + 2'd1;
							state <= ps2_pkg::SEND;
						end
					end else if (tick_100us) begin
						tick_cnt <= tick_cnt + 8'd1;
					end
				end
				default: state <= ps2_pkg::IDLE;
			endcase
		end
	end
endmodule

`default_nettype wire

// File: source/ps2_mouse_host.sv
`default_nettype none

module ps2_mouse_host (
	input  logic               qzt_clk,
	input  logic               rst,
	input  logic               trigger,
	input  logic               ps2_clk_in,
	input  logic               ps2_data_in,
	output logic               ps2_clk_drive_low,
	output logic               ps2_data_drive_low,
	output ps2_pkg::ps2_byte_t resp_byte,
	output logic               resp_valid,
	output logic               resp_err,
	output logic               cmd_nack,
	output logic               busy,
	output logic               seq_done
);
	logic sample_stb;
	logic tick_100us;

	ps2_link_if link ();

	////////////////////////////////////////////////////////////
	// timebase, then sequencer, then the line engines
	////////////////////////////////////////////////////////////
	ps2_timebase timebase0 (
		.qzt_clk    (qzt_clk),
		.rst        (rst),
		.sample_stb (sample_stb),
		.tick_100us (tick_100us)
	);

	ps2_init_seq seq0 (
		.qzt_clk    (qzt_clk),
		.rst        (rst),
		.tick_100us (tick_100us),
		.trigger    (trigger),
		.link       (link.seq),
		.resp_byte  (resp_byte),
		.resp_valid (resp_valid),
		.resp_err   (resp_err),
		.cmd_nack   (cmd_nack),
		.busy       (busy),
		.seq_done   (seq_done)
	);

	// only the transmit side ever pulls a line low
	ps2_host_tx tx0 (
		.qzt_clk        (qzt_clk),
		.rst            (rst),
		.sample_stb     (sample_stb),
		.tick_100us     (tick_100us),
		.link           (link.tx),
		.ps2_clk_in     (ps2_clk_in),
		.ps2_data_in    (ps2_data_in),
		.clk_drive_low  (ps2_clk_drive_low),
		.data_drive_low (ps2_data_drive_low)
	);

	ps2_host_rx rx0 (
		.qzt_clk     (qzt_clk),
		.rst         (rst),
		.sample_stb  (sample_stb),
		.link        (link.rx),
		.ps2_clk_in  (ps2_clk_in),
		.ps2_data_in (ps2_data_in)
	);
endmodule

`default_nettype wire

// File: sim/ps2_checker.sv
`default_nettype none

module ps2_checker (
	input  logic               qzt_clk,
	input  logic               rst,
	input  logic               trigger,
	input  logic               ps2_clk_drive_low,
	input  logic               ps2_data_drive_low,
	input  ps2_pkg::ps2_byte_t resp_byte,
	input  logic               resp_valid,
	input  logic               resp_err,
	input  logic               cmd_nack,
	input  logic               busy,
	input  logic               seq_done
);
	timeunit 1ns;
	timeprecision 1ps;

	// running pulse counts that are never cleared
	int valid_cnt = 0;
	int err_cnt = 0;
	int nack_cnt = 0;
	int done_cnt = 0;
	int frame_cnt = 0;
	// snapshots taken when a command is closed
	int valid_base = 0;
	int err_base = 0;
	int nack_base = 0;
	int done_base = 0;
	int check_errors = 0;
	int idle_errors = 0;
	int busy_errors = 0;
	ps2_pkg::ps2_byte_t last_resp;
	logic triggered = 1'b0;
	logic clk_drive_q = 1'b0;

	////////////////////////////////////////////////////////////
	// pulse counting
	////////////////////////////////////////////////////////////
	always @(posedge qzt_clk) begin
		clk_drive_q <= ps2_clk_drive_low;
		if (!rst) begin
			if (resp_valid) begin
				valid_cnt <= valid_cnt + 1;
				last_resp <= resp_byte;
			end
			if (resp_err)
				err_cnt <= err_cnt + 1;
			if (cmd_nack)
				nack_cnt <= nack_cnt + 1;
			if (seq_done)
				done_cnt <= done_cnt + 1;
			// a new host frame starts with the inhibit
			if (ps2_clk_drive_low && !clk_drive_q)
				frame_cnt <= frame_cnt + 1;
			if (trigger)
				triggered <= 1'b1;
			// everything quiet until the first trigger
			if (!triggered && idle_errors == 0 && (ps2_clk_drive_low || ps2_data_drive_low ||
					busy || seq_done || resp_valid || resp_err || cmd_nack)) begin
				$display("outputs active after reset before any trigger");
				idle_errors <= idle_errors + 1;
			end
			// every command frame runs while busy is high
			if (ps2_clk_drive_low && !busy && busy_errors == 0) begin
				$display("host held the clock low while busy was low");
				busy_errors <= busy_errors + 1;
			end
		end
	end

	function automatic void compare(string name, string what, int expected, int actual);
		if (expected != actual) begin
			$display("MISMATCH %s %s expected %0h actual %0h", name, what, expected, actual);
			check_errors++;
		end
	endfunction

	////////////////////////////////////////////////////////////
	// checks called from the testbench
	////////////////////////////////////////////////////////////

	// byte decoded by the device model
	task automatic check_host_frame(string name, int idx, ps2_pkg::ps2_byte_t data,
			logic parity, logic stop);
		compare(name, "host byte", int'(ps2_pkg::cmd_table[idx]), int'(data));
		compare(name, "odd parity", 1, int'(^{data, parity}));
		compare(name, "stop bit", 1, int'(stop));
	endtask

	// pulses seen since the last close
	task automatic close_command(string name, string kind, ps2_pkg::ps2_byte_t data,
			bit ack_withheld);
		int exp_valid;
		int exp_err;
		exp_valid = (!ack_withheld && kind == "good") ? 1 : 0;
		exp_err = (!ack_withheld && kind == "badpar") ? 1 : 0;
		compare(name, "resp_valid count", exp_valid, valid_cnt - valid_base);
		compare(name, "resp_err count", exp_err, err_cnt - err_base);
		compare(name, "cmd_nack count", ack_withheld ? 1 : 0, nack_cnt - nack_base);
		if (exp_valid == 1 && valid_cnt - valid_base == 1)
			compare(name, "resp_byte", int'(data), int'(last_resp));
		valid_base = valid_cnt;
		err_base = err_cnt;
		nack_base = nack_cnt;
	endtask

	task automatic close_sequence(string name, int exp_frames);
		compare(name, "seq_done count", 1, done_cnt - done_base);
		compare(name, "busy after seq_done", 0, int'(busy));
		compare(name, "host frame total", exp_frames, frame_cnt);
		done_base = done_cnt;
	endtask

	function automatic int error_total();
		return check_errors + idle_errors + busy_errors;
	endfunction
endmodule

`default_nettype wire

// File: sim/ps2_mouse_host_sva.sv
`default_nettype none

module ps2_mouse_host_sva (
	input logic qzt_clk,
	input logic rst,
	input logic ps2_clk_drive_low,
	input logic ps2_data_drive_low,
	input logic resp_valid,
	input logic resp_err,
	input logic busy,
	input logic seq_done
);
	timeunit 1ns;
	timeprecision 1ps;

	// request-to-send swaps clock for data on one edge
	no_double_drive: assert property (@(posedge qzt_clk) disable iff (rst)
		!(ps2_clk_drive_low && ps2_data_drive_low))
		else $error("clock and data driven low together");

	one_result: assert property (@(posedge qzt_clk) disable iff (rst)
		!(resp_valid && resp_err))
		else $error("resp_valid and resp_err high together");

	busy_ends_on_done: assert property (@(posedge qzt_clk) disable iff (rst)
		$fell(busy) |-> seq_done)
		else $error("busy dropped without seq_done");
endmodule

bind ps2_mouse_host ps2_mouse_host_sva sva0 (.*);

`default_nettype wire

// File: sim/tb_ps2_mouse_host.sv
`default_nettype none

module tb_ps2_mouse_host;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_ROWS = 6;
	localparam int INHIBIT_LIMIT = 200000;
	localparam int RTS_LIMIT = 5000;
	localparam int DONE_LIMIT = 100000;

	logic qzt_clk;
	logic rst;
	logic trigger;
	logic dev_clk_low;
	logic dev_data_low;
	logic ps2_clk_drive_low;
	logic ps2_data_drive_low;
	logic ps2_clk_line;
	logic ps2_data_line;
	ps2_pkg::ps2_byte_t resp_byte;
	logic resp_valid;
	logic resp_err;
	logic cmd_nack;
	logic busy;
	logic seq_done;

	// scenario table, three rows per sequence
	string              row_name [N_ROWS];
	string              row_kind [N_ROWS];
	ps2_pkg::ps2_byte_t row_byte [N_ROWS];
	bit                 row_nack [N_ROWS];

	integer seed = 32'hc264_0e94;
	int timeouts = 0;
	bit timed_out = 1'b0;

	// open-drain lines, low when either side pulls
	assign ps2_clk_line = ~(ps2_clk_drive_low | dev_clk_low);
	assign ps2_data_line = ~(ps2_data_drive_low | dev_data_low);

	ps2_mouse_host dut0 (
		.qzt_clk            (qzt_clk),
		.rst                (rst),
		.trigger            (trigger),
		.ps2_clk_in         (ps2_clk_line),
		.ps2_data_in        (ps2_data_line),
		.ps2_clk_drive_low  (ps2_clk_drive_low),
		.ps2_data_drive_low (ps2_data_drive_low),
		.resp_byte          (resp_byte),
		.resp_valid         (resp_valid),
		.resp_err           (resp_err),
		.cmd_nack           (cmd_nack),
		.busy               (busy),
		.seq_done           (seq_done)
	);

	ps2_checker chk0 (.*);

	initial begin
		qzt_clk = 1'b0;
		forever #50 qzt_clk = ~qzt_clk;
	end

	////////////////////////////////////////////////////////////
	// waits, each bounded
	////////////////////////////////////////////////////////////
	task automatic step();
		@(posedge qzt_clk);
		#5;
	endtask

	task automatic note_timeout(string what);
		$display("timeout while waiting for %s", what);
		timeouts++;
		timed_out = 1'b1;
	endtask

	task automatic wait_inhibit();
		int n;
		n = 0;
		while (!ps2_clk_drive_low && n < INHIBIT_LIMIT) begin
			step();
			n++;
		end
		if (!ps2_clk_drive_low)
			note_timeout("the host to hold the clock low");
	endtask

	task automatic wait_rts();
		int n;
		n = 0;
		while (!(ps2_data_drive_low && !ps2_clk_drive_low) && n < RTS_LIMIT) begin
			step();
			n++;
		end
		if (!(ps2_data_drive_low && !ps2_clk_drive_low))
			note_timeout("request-to-send");
	endtask

	task automatic wait_seq_done();
		int n;
		n = 0;
		while (!seq_done && n < DONE_LIMIT) begin
			step();
			n++;
		end
		if (!seq_done)
			note_timeout("seq_done");
	endtask

	task automatic pulse_trigger();
		trigger = 1'b1;
		step();
		trigger = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// device model
	////////////////////////////////////////////////////////////

	// 40 us device clock, low half then high half
	task automatic device_clock(output logic level_at_rise);
		dev_clk_low = 1'b1;
		#20000;
		dev_clk_low = 1'b0;
		level_at_rise = ps2_data_line;
		#20000;
	endtask

	task automatic receive_host_frame(bit withhold_ack, output ps2_pkg::ps2_frame_t bits);
		logic level;
		bits = '0;
		#20000;
		// host sets each bit after a falling edge, read on the rise
		for (int k = 1; k <= 10; k++) begin
			device_clock(level);
			bits[k] = level;
		end
		dev_data_low = !withhold_ack;
		device_clock(level);
		dev_data_low = 1'b0;
	endtask

	task automatic send_device_frame(ps2_pkg::ps2_byte_t data, bit bad_parity);
		ps2_pkg::ps2_frame_t bits;
		bits = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
		for (int k = 0; k <= 10; k++) begin
			dev_data_low = ~bits[k];
			#5000;
			dev_clk_low = 1'b1;
			#20000;
			dev_clk_low = 1'b0;
			#15000;
		end
		dev_data_low = 1'b0;
	endtask

	task automatic serve_row(int row, bit retrigger);
		ps2_pkg::ps2_frame_t bits;
		int pause;
		wait_inhibit();
		if (timed_out)
			return;
		// previous command's window is over once the next inhibit starts
		if (row % 3 != 0)
			chk0.close_command(row_name[row-1], row_kind[row-1], row_byte[row-1],
				row_nack[row-1]);
		// edge while busy must be ignored
		if (retrigger)
			pulse_trigger();
		wait_rts();
		if (timed_out)
			return;
		receive_host_frame(row_nack[row], bits);
		chk0.check_host_frame(row_name[row], row % 3, bits[8:1], bits[9], bits[10]);
		if (row_nack[row])
			return;
		#100000;
		if (row_kind[row] == "silent") begin
			pause = 1000 + ({$random(seed)} % 20000);
			repeat (pause) step();
		end else begin
			send_device_frame(row_byte[row], row_kind[row] == "badpar");
		end
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////
	initial begin
		row_name = '{"id_good", "stream_nack", "enable_badpar",
			"id_silent", "stream_good", "enable_good"};
		row_kind = '{"good", "good", "badpar", "silent", "good", "good"};
		row_byte = '{8'h00, 8'hFA, 8'hFA, 8'h00, 8'hFA, 8'hFA};
		row_nack = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
		rst = 1'b1;
		trigger = 1'b0;
		dev_clk_low = 1'b0;
		dev_data_low = 1'b0;
		repeat (2) step();
		rst = 1'b0;
		// quiet period before the first trigger
		repeat (300) step();
		for (int g = 0; g < N_ROWS / 3 && !timed_out; g++) begin
			pulse_trigger();
			for (int r = 0; r < 3 && !timed_out; r++)
				serve_row(g * 3 + r, g == 0 && r == 1);
			if (!timed_out)
				wait_seq_done();
			if (!timed_out) begin
				chk0.close_command(row_name[g*3+2], row_kind[g*3+2], row_byte[g*3+2],
					row_nack[g*3+2]);
				step();
				chk0.close_sequence(row_name[g*3+2], (g + 1) * 3);
				repeat (500) step();
			end
		end
		$display("check errors %0d, timeouts %0d", chk0.error_total(), timeouts);
		if (chk0.error_total() == 0 && timeouts == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end
endmodule

`default_nettype wire

// File: filelist.f
source/ps2_pkg.sv
source/ps2_link_if.sv
source/ps2_timebase.sv
source/ps2_host_tx.sv
source/ps2_host_rx.sv
source/ps2_init_seq.sv
source/ps2_mouse_host.sv
sim/ps2_checker.sv
sim/ps2_mouse_host_sva.sv
sim/tb_ps2_mouse_host.sv

// File: Makefile
TOP := tb_ps2_mouse_host

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
